// File: Makefile
TOP := tbMonsterSquad
SIM := obj_dir/V$(TOP)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qxF -e '** PASS **'

$(SIM): compile.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
gamePkg.sv
stageConfig.sv
monsterUnit.sv
monsterSprite.sv
overlapPicker.sv
monsterSquad.sv
tbMonsterSquad.sv

// File: gamePkg.sv
`default_nettype none

package gamePkg;

    // Squad size
    localparam int maxMonsters = 4;
    localparam int monsterIndexWidth = $clog2(maxMonsters);
    localparam int monsterCountWidth = $clog2(maxMonsters + 1);

    typedef logic [10:0] coordinate;
    typedef logic [7:0] rgbColor;
    typedef logic [2:0] stageNum;
    typedef logic [maxMonsters-1:0] monsterMask;
    typedef logic [monsterIndexWidth-1:0] monsterIndex;
    typedef logic [monsterCountWidth-1:0] monsterCount;

    typedef enum logic [1:0] {
        stateIdle,
        stateAlive,
        stateExploding,
        stateDead
    } monsterState;

    typedef struct packed {
        logic        drawRequest;
        monsterState state;
    } monsterView;

    // Sprite geometry in pixels
    localparam coordinate monsterSize = 11'd32;
    localparam coordinate cornerCut = 11'd4;

    // Row layout
    localparam coordinate initialX = 11'd64;
    localparam coordinate spacingX = 11'd96;
    localparam coordinate rowY = 11'd80;

    // Play-field borders, rightLimit bounds topLeftX plus monsterSize
    localparam coordinate leftLimit = 11'd16;
    localparam coordinate rightLimit = 11'd608;

    // Monster i moves baseSpeed plus i pixels per frame
    localparam coordinate baseSpeed = 11'd2;

    localparam int explosionFrames = 3;
    localparam int explodeCountWidth = $clog2(explosionFrames + 1);

    typedef logic [explodeCountWidth-1:0] explodeCount;

    // RRRGGGBB
    localparam rgbColor aliveColor = 8'b000_111_00;
    localparam rgbColor explodeColor = 8'b111_100_00;

    // Monsters taking part in each stage
    localparam monsterCount stageCounts [0:7] = '{
        monsterCount'(0),
        monsterCount'(2),
        monsterCount'(4),
        monsterCount'(3),
        monsterCount'(1),
        monsterCount'(0),
        monsterCount'(0),
        monsterCount'(0)
    };

endpackage

`default_nettype wire

// File: monsterSprite.sv
`timescale 1ns/1ps
`default_nettype none

module monsterSprite
    import gamePkg::*;
(
    input  logic        clk,
    input  logic        resetN,
    input  coordinate   pixelX,
    input  coordinate   pixelY,
    input  coordinate   topLeftX,
    input  monsterState state,
    output monsterView  view
);

    coordinate offsetX;
    coordinate offsetY;
    logic      insideBox;
    logic      cornerX;
    logic      cornerY;
    logic      visible;
    logic      drawNow;

    assign offsetX = pixelX - topLeftX;
    assign offsetY = pixelY - rowY;

    assign insideBox = (pixelX >= topLeftX) && (pixelX < topLeftX + monsterSize)
                    && (pixelY >= rowY) && (pixelY < rowY + monsterSize);

    // Near a vertical or horizontal edge of the box
    assign cornerX = (offsetX < cornerCut) || (offsetX >= monsterSize - cornerCut);
    assign cornerY = (offsetY < cornerCut) || (offsetY >= monsterSize - cornerCut);

    assign visible = (state == stateAlive) || (state == stateExploding);
    assign drawNow = insideBox && !(cornerX && cornerY) && visible;

    // State travels with the draw request so the picker sees a matching pair
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            view.drawRequest <= 1'b0;
            view.state <= stateIdle;
        end else begin
            view.drawRequest <= drawNow;
            view.state <= state;
        end
    end

endmodule

`default_nettype wire

// File: monsterSquad.sv
`timescale 1ns/1ps
`default_nettype none

module monsterSquad
    import gamePkg::*;
(
    input  logic      clk,
    input  logic      resetN,
    input  logic      enable,
    input  logic      startOfFrame,
    input  logic      collision,
    input  stageNum   stage,
    input  coordinate pixelX,
    input  coordinate pixelY,
    output logic      monsterDR,
    output rgbColor   monsterRGB,
    output logic      monsterDiedPulse,
    output logic      allMonstersDead
);

    logic                         frameTick;
    monsterMask                   activeMask;
    monsterMask                   chosenMask;
    monsterMask                   lastChosen;
    monsterMask                   hitStrobe;
    monsterMask                   aliveMask;
    monsterMask                   deadMask;
    coordinate [maxMonsters-1:0]  topLeftX;
    monsterState                  unitState [maxMonsters];
    monsterView [maxMonsters-1:0] views;

    assign frameTick = startOfFrame & enable;

    stageConfig stageConfig_i (
        .clk          (clk),
        .resetN       (resetN),
        .startOfFrame (startOfFrame),
        .stage        (stage),
        .activeMask   (activeMask)
    );

    for (genvar i = 0; i < maxMonsters; i++) begin : slice
        monsterUnit monsterUnit_i (
            .clk       (clk),
            .resetN    (resetN),
            .frameTick (frameTick),
            .active    (activeMask[i]),
            .hit       (hitStrobe[i]),
            .monsterId (monsterIndex'(i)),
            .topLeftX  (topLeftX[i]),
            .state     (unitState[i])
        );

        monsterSprite monsterSprite_i (
            .clk      (clk),
            .resetN   (resetN),
            .pixelX   (pixelX),
            .pixelY   (pixelY),
            .topLeftX (topLeftX[i]),
            .state    (unitState[i]),
            .view     (views[i])
        );

        assign aliveMask[i] = (unitState[i] == stateAlive);
        assign deadMask[i] = (unitState[i] == stateDead);
    end

    overlapPicker overlapPicker_i (
        .clk        (clk),
        .resetN     (resetN),
        .views      (views),
        .monsterDR  (monsterDR),
        .monsterRGB (monsterRGB),
        .chosenMask (chosenMask)
    );

    // The collision strobe refers to the pixel shown one cycle earlier
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lastChosen <= '0;
        end else begin
            lastChosen <= chosenMask;
        end
    end

    assign hitStrobe = lastChosen & {maxMonsters{collision}};

    // Lines up with the alive to exploding step in the hit monster
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            monsterDiedPulse <= 1'b0;
        end else begin
            monsterDiedPulse <= |(hitStrobe & aliveMask);
        end
    end

    assign allMonstersDead = (activeMask != '0) && ((deadMask & activeMask) == activeMask);

endmodule

`default_nettype wire

// File: monsterUnit.sv
`timescale 1ns/1ps
`default_nettype none

module monsterUnit
    import gamePkg::*;
(
    input  logic        clk,
    input  logic        resetN,
    input  logic        frameTick,
    input  logic        active,
    input  logic        hit,
    input  monsterIndex monsterId,
    output coordinate   topLeftX,
    output monsterState state
);

    coordinate   startX;
    coordinate   step;
    coordinate   rightX;
    coordinate   leftX;
    logic        bounceRight;
    logic        bounceLeft;
    logic        movingRight;
    explodeCount frameCount;

    assign startX = initialX + spacingX * coordinate'(monsterId);
    assign step = baseSpeed + coordinate'(monsterId);

    // Candidate positions and border checks for this tick
    assign rightX = topLeftX + step;
    assign leftX = topLeftX - step;
    assign bounceRight = (rightX + monsterSize) > rightLimit;
    assign bounceLeft = topLeftX < (leftLimit + step);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= stateIdle;
            topLeftX <= startX;
            movingRight <= 1'b1;
            frameCount <= '0;
        end else if (hit && state == stateAlive) begin
            // Hit wins over a tick in the same cycle
            state <= stateExploding;
            frameCount <= '0;
        end else if (frameTick) begin
            if (!active) begin
                state <= stateIdle;
                topLeftX <= startX;
                movingRight <= 1'b1;
                frameCount <= '0;
            end else begin
                case (state)
                    stateIdle: begin
                        // Wakes up in place, first step on the next tick
                        state <= stateAlive;
                    end
                    stateAlive: begin
                        if (movingRight) begin
                            if (bounceRight) begin
                                movingRight <= 1'b0;
                            end else begin
                                topLeftX <= rightX;
                            end
                        end else begin
                            if (bounceLeft) begin
                                movingRight <= 1'b1;
                            end else begin
                                topLeftX <= leftX;
                            end
                        end
                    end
                    stateExploding: begin
                        if (frameCount == explodeCount'(explosionFrames - 1)) begin
                            state <= stateDead;
                        end else begin
                            frameCount <= frameCount + 1'b1;
                        end
                    end
                    default: begin
                        state <= stateDead;
                    end
                endcase
            end
        end
    end

    positionInField: assert property (
        @(posedge clk) disable iff (!resetN)
        (topLeftX >= leftLimit) && ((topLeftX + monsterSize) <= rightLimit)
    ) else $error("monster %0d left the play field at x=%0d", monsterId, topLeftX);

    // Only dropping out of the stage brings a dead monster back
    deadStaysDead: assert property (
        @(posedge clk) disable iff (!resetN)
        (state == stateDead && active) |=> (state == stateDead)
    ) else $error("monster %0d left dead while still active", monsterId);

endmodule

`default_nettype wire

// File: overlapPicker.sv
`timescale 1ns/1ps
`default_nettype none

module overlapPicker
    import gamePkg::*;
(
    input  logic                         clk,
    input  logic                         resetN,
    input  monsterView [maxMonsters-1:0] views,
    output logic                         monsterDR,
    output rgbColor                      monsterRGB,
    output monsterMask                   chosenMask
);

    logic        anyDraw;
    monsterMask  drawBits;
    monsterIndex winner;
    monsterIndex chosenIndex;
    rgbColor     winnerColor;

    // Lowest index wins, so scan downwards and let the last match stand
    always_comb begin
        anyDraw = 1'b0;
        drawBits = '0;
        winner = '0;
        for (int i = maxMonsters - 1; i >= 0; i--) begin
            drawBits[i] = views[i].drawRequest;
            if (views[i].drawRequest) begin
                anyDraw = 1'b1;
                winner = monsterIndex'(i);
            end
        end
    end

    assign winnerColor = (views[winner].state == stateExploding) ? explodeColor : aliveColor;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            monsterDR <= 1'b0;
            monsterRGB <= '0;
            chosenIndex <= '0;
        end else begin
            monsterDR <= anyDraw;
            monsterRGB <= anyDraw ? winnerColor : '0;
            chosenIndex <= winner;
        end
    end

    assign chosenMask = monsterDR ? (monsterMask'(1) << chosenIndex) : '0;

    // Owner is the lowest set bit of the previous cycle's draw requests
    lowestOwner: assert property (
        @(posedge clk) disable iff (!resetN)
        chosenMask == ($past(drawBits) & monsterMask'(~$past(drawBits) + 1'b1))
    ) else $error("chosenMask %b is not the lowest drawing monster", chosenMask);

endmodule

`default_nettype wire

// File: stageConfig.sv
`timescale 1ns/1ps
`default_nettype none

module stageConfig
    import gamePkg::*;
(
    input  logic       clk,
    input  logic       resetN,
    input  logic       startOfFrame,
    input  stageNum    stage,
    output monsterMask activeMask
);

    monsterCount count;
    monsterMask  nextMask;

    assign count = stageCounts[stage];

    // Thermometer code, bits below the count are set
    always_comb begin
        nextMask = '0;
        for (int i = 0; i < maxMonsters; i++) begin
            nextMask[i] = (monsterCount'(i) < count);
        end
    end

    // Sampled once per frame so a mid-frame stage change waits for the next frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            activeMask <= '0;
        end else if (startOfFrame) begin
            activeMask <= nextMask;
        end
    end

    maskIsContiguous: assert property (
        @(posedge clk) disable iff (!resetN)
        ((monsterMask'(activeMask + 1'b1) & activeMask) == '0)
    ) else $error("activeMask is not a run of ones from bit 0");

endmodule

`default_nettype wire

// File: tbMonsterSquad.sv
`timescale 1ns/1ps
`default_nettype none

module tbMonsterSquad
    import gamePkg::*;
();

    localparam int clockPeriod = 8;
    // Longest run is a few thousand cycles, so this leaves ample margin
    localparam int timeoutCycles = 20000;
    localparam int stageTable [0:7] = '{0, 2, 4, 3, 1, 0, 0, 0};
    localparam int sizePx = monsterSize;
    localparam int cutPx = cornerCut;
    localparam int rowPx = rowY;

    logic        clk;
    logic        resetN;
    logic        enable;
    logic        startOfFrame;
    logic        collision;
    stageNum     stage;
    coordinate   pixelX;
    coordinate   pixelY;
    logic        monsterDR;
    rgbColor     monsterRGB;
    logic        monsterDiedPulse;
    logic        allMonstersDead;

    // Reference model of the squad
    monsterState modelState [maxMonsters];
    int          moveCount [maxMonsters];
    int          explodeTicks [maxMonsters];
    monsterMask  modelMask;

    logic [31:0] rngState;
    string       testName;
    int          cycleCount = 0;

    // Expected pixel results travel two cycles behind the driven pixel
    logic        pendValid = 1'b0;
    logic        midValid = 1'b0;
    logic        lateValid = 1'b0;
    logic [8:0]  pendExp;
    logic [8:0]  midExp;
    logic [8:0]  lateExp;
    string       pendName;
    string       midName;
    string       lateName;

    monsterSquad dut_i (
        .clk              (clk),
        .resetN           (resetN),
        .enable           (enable),
        .startOfFrame     (startOfFrame),
        .collision        (collision),
        .stage            (stage),
        .pixelX           (pixelX),
        .pixelY           (pixelY),
        .monsterDR        (monsterDR),
        .monsterRGB       (monsterRGB),
        .monsterDiedPulse (monsterDiedPulse),
        .allMonstersDead  (allMonstersDead)
    );

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= timeoutCycles);
        $display("Timeout: the testbench did not finish within %0d cycles", timeoutCycles);
        $display("** FAIL **");
        $fatal(1, "Simulation hung");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Replays the bounce rule tick by tick
    function automatic int xOf(input int i, input int frames);
        int x;
        int step;
        bit right;
        x = int'(initialX) + int'(spacingX) * i;
        step = int'(baseSpeed) + i;
        right = 1'b1;
        for (int f = 0; f < frames; f++) begin
            if (right) begin
                if (x + step + sizePx > int'(rightLimit)) begin
                    right = 1'b0;
                end else begin
                    x = x + step;
                end
            end else begin
                if (x - step < int'(leftLimit)) begin
                    right = 1'b1;
                end else begin
                    x = x - step;
                end
            end
        end
        return x;
    endfunction

    // Lowest visible monster covering the pixel, or -1
    function automatic int winnerOf(input int px, input int py);
        int  win;
        int  dx;
        int  dy;
        bit  edgeH;
        bit  edgeV;
        win = -1;
        for (int i = maxMonsters - 1; i >= 0; i--) begin
            dx = px - xOf(i, moveCount[i]);
            dy = py - rowPx;
            edgeH = (dx < cutPx) || (dx >= sizePx - cutPx);
            edgeV = (dy < cutPx) || (dy >= sizePx - cutPx);
            if ((modelState[i] == stateAlive || modelState[i] == stateExploding)
                    && dx >= 0 && dx < sizePx && dy >= 0 && dy < sizePx
                    && !(edgeH && edgeV)) begin
                win = i;
            end
        end
        return win;
    endfunction

    function automatic logic [8:0] expectPixel(input int px, input int py);
        int         win;
        logic [8:0] result;
        win = winnerOf(px, py);
        if (win < 0) begin
            result = 9'h000;
        end else if (modelState[win] == stateExploding) begin
            result = {1'b1, explodeColor};
        end else begin
            result = {1'b1, aliveColor};
        end
        return result;
    endfunction

    function automatic monsterMask thermometer(input int count);
        monsterMask mask;
        mask = '0;
        for (int i = 0; i < maxMonsters; i++) begin
            mask[i] = (i < count);
        end
        return mask;
    endfunction

    function automatic logic expectAllDead();
        logic allDead;
        allDead = (modelMask != '0);
        for (int i = 0; i < maxMonsters; i++) begin
            if (modelMask[i] && modelState[i] != stateDead) begin
                allDead = 1'b0;
            end
        end
        return allDead;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    always @(posedge clk) begin
        midValid <= pendValid;
        midExp <= pendExp;
        midName <= pendName;
        lateValid <= midValid;
        lateExp <= midExp;
        lateName <= midName;
    end

    // Outputs for a pixel are registered two edges after it was driven
    always @(negedge clk) begin
        if (lateValid) begin
            compareValue({lateName, " DR"}, lateExp[8], monsterDR);
            if (lateExp[8]) begin
                compareValue({lateName, " RGB"}, lateExp[7:0], monsterRGB);
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Units see the mask from before this tick
    task automatic advanceModel();
        for (int i = 0; i < maxMonsters; i++) begin
            if (!modelMask[i]) begin
                modelState[i] = stateIdle;
                moveCount[i] = 0;
                explodeTicks[i] = 0;
            end else if (modelState[i] == stateIdle) begin
                modelState[i] = stateAlive;
            end else if (modelState[i] == stateAlive) begin
                moveCount[i]++;
            end else if (modelState[i] == stateExploding) begin
                explodeTicks[i]++;
                if (explodeTicks[i] == explosionFrames) begin
                    modelState[i] = stateDead;
                end
            end
        end
    endtask

    task automatic frame(input logic en);
        nextCycle();
        pendValid = 1'b0;
        startOfFrame = 1'b1;
        enable = en;
        if (en) begin
            advanceModel();
        end
        modelMask = thermometer(stageTable[stage]);
        nextCycle();
        startOfFrame = 1'b0;
        enable = 1'b1;
        compareValue({testName, " allDead"}, expectAllDead(), allMonstersDead);
    endtask

    task automatic samplePixel(input int px, input int py);
        nextCycle();
        pixelX = coordinate'(px);
        pixelY = coordinate'(py);
        pendValid = 1'b1;
        pendExp = expectPixel(px, py);
        pendName = testName;
    endtask

    task automatic randomPixels(input int count);
        int i;
        int px;
        int py;
        repeat (count) begin
            rngState = xorshift32(rngState);
            i = int'(rngState[1:0]);
            px = xOf(i, moveCount[i]) - 4 + int'(rngState[7:2]) % 40;
            py = rowPx - 4 + int'(rngState[15:10]) % 40;
            samplePixel(px, py);
        end
    endtask

    // Shows the centre pixel, then collides in the cycle after it is output
    task automatic hitMonster(input int i);
        int   px;
        int   py;
        int   win;
        int   pulses;
        logic expectPulse;
        px = xOf(i, moveCount[i]) + sizePx / 2;
        py = rowPx + sizePx / 2;
        win = winnerOf(px, py);
        samplePixel(px, py);
        nextCycle();
        pendValid = 1'b0;
        pixelX = '0;
        pixelY = '0;
        nextCycle();
        nextCycle();
        collision = 1'b1;
        expectPulse = (win >= 0) && (modelState[win] == stateAlive);
        if (expectPulse) begin
            modelState[win] = stateExploding;
            explodeTicks[win] = 0;
        end
        pulses = 0;
        repeat (4) begin
            nextCycle();
            collision = 1'b0;
            if (monsterDiedPulse === 1'b1) begin
                pulses++;
            end
        end
        compareValue({testName, " pulses"}, expectPulse ? 1 : 0, pulses);
    endtask

    initial begin
        resetN = 1'b0;
        enable = 1'b1;
        startOfFrame = 1'b0;
        collision = 1'b0;
        stage = 3'd2;
        pixelX = '0;
        pixelY = '0;
        pendExp = '0;
        pendName = "reset";
        testName = "reset";
        rngState = 32'h76b2fadc;
        modelMask = '0;
        for (int i = 0; i < maxMonsters; i++) begin
            modelState[i] = stateIdle;
            moveCount[i] = 0;
            explodeTicks[i] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        resetN = 1'b1;
        compareValue("reset DR", 0, monsterDR);
        compareValue("reset pulse", 0, monsterDiedPulse);
        compareValue("reset allDead", 0, allMonstersDead);

        testName = "stage2 pixels";
        repeat (6) frame(1'b1);
        randomPixels(200);

        // Monster 0 reaches the right border after about 255 moves
        testName = "bounce";
        repeat (14) begin
            repeat (20) frame(1'b1);
            randomPixels(20);
        end
        testName = "enable low";
        repeat (5) frame(1'b0);
        randomPixels(60);

        testName = "stage3";
        stage = 3'd3;
        repeat (4) frame(1'b1);
        randomPixels(100);
        testName = "stage0";
        stage = 3'd0;
        repeat (3) frame(1'b1);
        randomPixels(60);

        testName = "hit";
        stage = 3'd2;
        repeat (3) frame(1'b1);
        hitMonster(1);
        randomPixels(60);
        frame(1'b1);
        testName = "second hit";
        hitMonster(1);
        repeat (2) frame(1'b1);
        testName = "after explosion";
        randomPixels(60);

        testName = "stage1 clear";
        stage = 3'd0;
        repeat (2) frame(1'b1);
        stage = 3'd1;
        repeat (2) frame(1'b1);
        hitMonster(0);
        hitMonster(1);
        repeat (3) frame(1'b1);
        compareValue("stage1 clear final", 1, allMonstersDead);

        repeat (3) nextCycle();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
